// ==== Bender.yml ====
package:
  name: l1d_cache

sources:
  - files:
      - hw/l1d_pkg.sv
      - hw/way_array.sv
      - hw/way_select.sv
      - hw/l1d_fsm.sv
      - hw/l1d_top.sv
  - target: test
    files:
      - bench/mem_model.sv
      - bench/l1d_tb.sv

// ==== bench/l1d_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module l1d_tb;

    localparam int N_REQ      = 300;
    localparam int MAX_CYCLES = (N_REQ + 2) * 200 + 1000;

    logic                clk_i;
    logic                rstn_i;
    l1d_pkg::cache_req_t req;
    logic                req_valid;
    logic                req_ready;
    l1d_pkg::word_t      rsp_data;
    logic                rsp_valid;
    logic                rsp_ready;
    l1d_pkg::mem_req_t   mem_req;
    logic                mem_req_valid;
    logic                mem_req_ready;
    l1d_pkg::block_t     mem_rsp_data;
    logic                mem_rsp_valid;
    logic                mem_rsp_ready;

    integer         seed;
    int             cycles;
    int             checks;
    int             errors;
    int             wb_count;
    int             fill_count;
    l1d_pkg::word_t model [l1d_pkg::addr_t];

    l1d_top UUT (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .req_i           (req),
        .req_valid_i     (req_valid),
        .req_ready_o     (req_ready),
        .rsp_data_o      (rsp_data),
        .rsp_valid_o     (rsp_valid),
        .rsp_ready_i     (rsp_ready),
        .mem_req_o       (mem_req),
        .mem_req_valid_o (mem_req_valid),
        .mem_req_ready_i (mem_req_ready),
        .mem_rsp_data_i  (mem_rsp_data),
        .mem_rsp_valid_i (mem_rsp_valid),
        .mem_rsp_ready_o (mem_rsp_ready)
    );

    mem_model #(
        .SEED (76)
    ) u_mem (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .mem_req_i       (mem_req),
        .mem_req_valid_i (mem_req_valid),
        .mem_req_ready_o (mem_req_ready),
        .mem_rsp_data_o  (mem_rsp_data),
        .mem_rsp_valid_o (mem_rsp_valid),
        .mem_rsp_ready_i (mem_rsp_ready)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // Same start pattern as the memory model
    function automatic l1d_pkg::word_t init_word(l1d_pkg::addr_t addr);
        return (addr ^ 32'hA5C3_0000) + {addr[15:0], addr[31:16]};
    endfunction

    function automatic l1d_pkg::word_t model_word(l1d_pkg::addr_t addr);
        if (model.exists(addr)) begin
            return model[addr];
        end
        return init_word(addr);
    endfunction

    // Word 0 sits in the low bits of a block
    function automatic l1d_pkg::block_t model_block(l1d_pkg::addr_t addr);
        l1d_pkg::block_t blk;
        for (int w = 0; w < 4; w++) begin
            blk[w*32 +: 32] = model_word({addr[31:4], 4'b0000} + l1d_pkg::addr_t'(4 * w));
        end
        return blk;
    endfunction

    function automatic int unsigned rand_below(int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // Six tags over eight sets overflow the four ways of a set
    function automatic l1d_pkg::addr_t rand_addr();
        logic [23:0] tag;
        logic [3:0]  set;
        logic [1:0]  word;
        tag  = 24'h001230 + 24'(rand_below(6));
        set  = 4'(rand_below(8));
        word = 2'(rand_below(4));
        return {tag, set, word, 2'b00};
    endfunction

    task automatic compare_value(input string name, input logic [127:0] exp,
                                 input logic [127:0] act);
        checks++;
        assert (exp === act) else begin
            errors++;
            $display("[FAIL] %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    task automatic confirm(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("ERROR: %s", what);
        end
    endtask

    // Starts and ends on a falling edge
    task automatic issue_request(input logic wr, input l1d_pkg::addr_t addr,
                                 input l1d_pkg::word_t data, output int acc_cycle);
        req       = '{write: wr, addr: addr, data: data};
        req_valid = 1'b1;
        while (!req_ready) @(negedge clk_i);
        @(negedge clk_i);
        req_valid = 1'b0;
        acc_cycle = cycles;
    endtask

    task automatic write_word(input l1d_pkg::addr_t addr, input l1d_pkg::word_t data);
        int acc;
        issue_request(1'b1, addr, data, acc);
        model[addr] = data;
    endtask

    task automatic read_word(input string name, input l1d_pkg::addr_t addr,
                             input logic stall, output int latency);
        l1d_pkg::word_t exp;
        l1d_pkg::word_t held;
        logic           holding;
        logic           done;
        int             acc;
        exp     = model_word(addr);
        holding = 1'b0;
        done    = 1'b0;
        latency = 0;
        issue_request(1'b0, addr, '0, acc);
        while (!done) begin
            rsp_ready = stall ? (rand_below(4) != 0) : 1'b1;
            if (rsp_valid) begin
                if (!holding) begin
                    latency = cycles + 1 - acc;
                end else begin
                    compare_value({name, "_hold"}, held, rsp_data);
                end
                confirm(!req_ready, "request ready while a response is pending");
                holding = 1'b1;
                held    = rsp_data;
                if (rsp_ready) begin
                    compare_value(name, exp, rsp_data);
                    done = 1'b1;
                end
            end else begin
                confirm(!holding, "response valid dropped before it was taken");
            end
            @(negedge clk_i);
        end
    endtask

    // Memory channel transfers
    always @(posedge clk_i) begin
        if (rstn_i && mem_req_valid && mem_req_ready) begin
            confirm(mem_req.addr[3:0] == 4'b0000, "memory request address not block aligned");
            if (mem_req.write) begin
                wb_count++;
                compare_value("writeback_data", model_block(mem_req.addr), mem_req.data);
            end else begin
                fill_count++;
            end
        end
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("ERROR: timeout after %0d cycles", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        l1d_pkg::addr_t addr;
        int             lat;
        int             fills;
        seed       = 76;
        checks     = 0;
        errors     = 0;
        wb_count   = 0;
        fill_count = 0;
        rstn_i     = 1'b0;
        req        = '0;
        req_valid  = 1'b0;
        rsp_ready  = 1'b0;
        repeat (3) @(negedge clk_i);
        rstn_i = 1'b1;
        @(negedge clk_i);

        compare_value("reset_req_ready", 1'b1, req_ready);
        compare_value("reset_rsp_valid", 1'b0, rsp_valid);
        compare_value("reset_mem_req_valid", 1'b0, mem_req_valid);
        compare_value("reset_mem_rsp_ready", 1'b0, mem_rsp_ready);

        addr  = {24'h001230, 4'd5, 2'd1, 2'b00};
        fills = fill_count;
        read_word("cold_read", addr, 1'b0, lat);
        compare_value("cold_read_fills", fills + 1, fill_count);
        read_word("hit_read", addr, 1'b0, lat);
        compare_value("hit_latency", 2, lat);

        for (int i = 0; i < N_REQ; i++) begin
            addr = rand_addr();
            if (rand_below(2) != 0) begin
                write_word(addr, l1d_pkg::word_t'($random(seed)));
            end else begin
                read_word("random_read", addr, 1'b1, lat);
            end
        end
        while (!req_ready) @(negedge clk_i);
        repeat (2) @(negedge clk_i);

        confirm(wb_count > 0, "no dirty write-back happened during the run");
        $display("Checks: %0d  Errors: %0d  Write-backs: %0d  Fills: %0d",
                 checks, errors, wb_count, fill_count);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/mem_model.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_model #(
    parameter int SEED = 76
) (
    input  logic                clk_i,
    input  logic                rstn_i,

    input  l1d_pkg::mem_req_t   mem_req_i,
    input  logic                mem_req_valid_i,
    output logic                mem_req_ready_o,

    output l1d_pkg::block_t     mem_rsp_data_o,
    output logic                mem_rsp_valid_o,
    input  logic                mem_rsp_ready_i
);

    l1d_pkg::block_t mem [l1d_pkg::addr_t];
    integer          seed;

    // Every word starts as a mix of its own byte address
    function automatic l1d_pkg::word_t init_word(l1d_pkg::addr_t addr);
        return (addr ^ 32'hA5C3_0000) + {addr[15:0], addr[31:16]};
    endfunction

    function automatic l1d_pkg::block_t read_block(l1d_pkg::addr_t addr);
        l1d_pkg::block_t blk;
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        for (int w = 0; w < 4; w++) begin
            blk[w*32 +: 32] = init_word(addr + l1d_pkg::addr_t'(4 * w));
        end
        return blk;
    endfunction

    initial begin
        l1d_pkg::mem_req_t req;
        seed            = SEED;
        mem_req_ready_o = 1'b0;
        mem_rsp_valid_o = 1'b0;
        mem_rsp_data_o  = '0;
        forever begin
            @(negedge clk_i);
            if (rstn_i && mem_req_valid_i) begin
                req = mem_req_i;
                repeat ($unsigned($random(seed)) % 4) @(negedge clk_i);
                mem_req_ready_o = 1'b1;
                @(negedge clk_i);
                mem_req_ready_o = 1'b0;
                if (req.write) begin
                    mem[req.addr] = req.data;
                end else begin
                    repeat ($unsigned($random(seed)) % 5) @(negedge clk_i);
                    mem_rsp_valid_o = 1'b1;
                    mem_rsp_data_o  = read_block(req.addr);
                    while (!mem_rsp_ready_i) @(negedge clk_i);
                    @(negedge clk_i);
                    mem_rsp_valid_o = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/l1d_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

module l1d_fsm (
    input  logic                                      clk_i,
    input  logic                                      rstn_i,

    input  l1d_pkg::cache_req_t                       req_i,
    input  logic                                      req_valid_i,
    output logic                                      req_ready_o,

    output l1d_pkg::word_t                            rsp_data_o,
    output logic                                      rsp_valid_o,
    input  logic                                      rsp_ready_i,

    output l1d_pkg::mem_req_t                         mem_req_o,
    output logic                                      mem_req_valid_o,
    input  logic                                      mem_req_ready_i,

    input  l1d_pkg::block_t                           mem_rsp_data_i,
    input  logic                                      mem_rsp_valid_i,
    output logic                                      mem_rsp_ready_o,

    input  l1d_pkg::tag_entry_t [l1d_pkg::WAYS-1:0]   tag_rd_i,
    input  l1d_pkg::block_t [l1d_pkg::WAYS-1:0]       blk_rd_i,

    input  logic                                      hit_i,
    input  l1d_pkg::way_idx_t                         hit_way_i,
    input  l1d_pkg::way_idx_t                         victim_way_i,
    output logic                                      evict_o,
    output l1d_pkg::tag_t                             cmp_tag_o,

    output l1d_pkg::set_idx_t                         arr_rd_set_o,
    output logic                                      tag_wr_en_o,
    output logic                                      blk_wr_en_o,
    output l1d_pkg::set_idx_t                         arr_wr_set_o,
    output l1d_pkg::way_idx_t                         arr_wr_way_o,
    output l1d_pkg::tag_entry_t                       tag_wr_o,
    output l1d_pkg::block_t                           blk_wr_o
);

    typedef enum logic [2:0] {
        IDLE,
        COMPARE,
        WRITEBACK,
        FILL_REQ,
        FILL_WAIT,
        REREAD,
        RESPOND
    } state_e;

    state_e              state_r;
    state_e              state_ns;
    l1d_pkg::cache_req_t req_r;
    l1d_pkg::way_idx_t   victim_r;
    l1d_pkg::mem_req_t   mem_req_r;
    l1d_pkg::mem_req_t   mem_req_ns;
    l1d_pkg::mem_req_t   fill_req;
    l1d_pkg::word_t      rsp_data_r;
    l1d_pkg::tag_entry_t victim_entry;

    logic accept;
    logic rd_hit;
    logic wr_hit;
    logic fill_done;

    function automatic l1d_pkg::word_t get_word(l1d_pkg::block_t blk, l1d_pkg::word_idx_t idx);
        return blk[idx * l1d_pkg::WORD_W +: l1d_pkg::WORD_W];
    endfunction

    function automatic l1d_pkg::block_t put_word(l1d_pkg::block_t blk,
                                                 l1d_pkg::word_idx_t idx,
                                                 l1d_pkg::word_t word);
        l1d_pkg::block_t res;
        res = blk;
        res[idx * l1d_pkg::WORD_W +: l1d_pkg::WORD_W] = word;
        return res;
    endfunction

    assign accept          = (state_r == IDLE) && req_valid_i;
    assign req_ready_o     = (state_r == IDLE);
    assign rsp_valid_o     = (state_r == RESPOND);
    assign rsp_data_o      = rsp_data_r;
    assign mem_req_valid_o = (state_r == WRITEBACK) || (state_r == FILL_REQ);
    assign mem_req_o       = mem_req_r;
    assign mem_rsp_ready_o = (state_r == FILL_WAIT);

    assign victim_entry = tag_rd_i[victim_way_i];
    assign rd_hit       = (state_r == COMPARE) && hit_i && !req_r.write;
    assign wr_hit       = (state_r == COMPARE) && hit_i && req_r.write;
    assign fill_done    = (state_r == FILL_WAIT) && mem_rsp_valid_i;
    // Only a valid victim counts as an eviction
    assign evict_o      = (state_r == COMPARE) && !hit_i && victim_entry.valid;
    assign cmp_tag_o    = l1d_pkg::addr_tag(req_r.addr);

    assign fill_req = '{
        write: 1'b0,
        addr:  l1d_pkg::block_addr(l1d_pkg::addr_tag(req_r.addr), l1d_pkg::addr_set(req_r.addr)),
        data:  '0
    };

    // Array port control
    assign arr_rd_set_o = accept ? l1d_pkg::addr_set(req_i.addr) : l1d_pkg::addr_set(req_r.addr);
    assign arr_wr_set_o = l1d_pkg::addr_set(req_r.addr);
    assign arr_wr_way_o = (state_r == FILL_WAIT) ? victim_r : hit_way_i;
    // Tag rewrite on a write hit only when the dirty bit changes
    assign tag_wr_en_o  = fill_done || (wr_hit && !tag_rd_i[hit_way_i].dirty);
    assign blk_wr_en_o  = fill_done || wr_hit;
    assign tag_wr_o     = '{
        valid: 1'b1,
        dirty: (state_r == COMPARE),
        tag:   l1d_pkg::addr_tag(req_r.addr)
    };
    assign blk_wr_o     = fill_done ? mem_rsp_data_i
                        : put_word(blk_rd_i[hit_way_i], l1d_pkg::addr_word(req_r.addr), req_r.data);

    always_comb begin
        state_ns   = state_r;
        mem_req_ns = mem_req_r;
        unique case (state_r)
            IDLE: begin
                if (req_valid_i) begin
                    state_ns = COMPARE;
                end
            end
            COMPARE: begin
                if (hit_i) begin
                    state_ns = req_r.write ? IDLE : RESPOND;
                end else if (victim_entry.valid && victim_entry.dirty) begin
                    mem_req_ns = '{
                        write: 1'b1,
                        addr:  l1d_pkg::block_addr(victim_entry.tag,
                                                   l1d_pkg::addr_set(req_r.addr)),
                        data:  blk_rd_i[victim_way_i]
                    };
                    state_ns   = WRITEBACK;
                end else begin
                    mem_req_ns = fill_req;
                    state_ns   = FILL_REQ;
                end
            end
            WRITEBACK: begin
                if (mem_req_ready_i) begin
                    mem_req_ns = fill_req;
                    state_ns   = FILL_REQ;
                end
            end
            FILL_REQ: begin
                if (mem_req_ready_i) begin
                    state_ns = FILL_WAIT;
                end
            end
            FILL_WAIT: begin
                if (mem_rsp_valid_i) begin
                    state_ns = REREAD;
                end
            end
            // Fill lands in the arrays at this edge, read the set again
            REREAD: begin
                state_ns = COMPARE;
            end
            RESPOND: begin
                if (rsp_ready_i) begin
                    state_ns = IDLE;
                end
            end
            default: begin
                state_ns = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_r <= IDLE;
            req_r   <= '0;
        end else begin
            state_r <= state_ns;
            if (accept) begin
                req_r <= req_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        mem_req_r <= mem_req_ns;
        if ((state_r == COMPARE) && !hit_i) begin
            victim_r <= victim_way_i;
        end
        if (rd_hit) begin
            rsp_data_r <= get_word(blk_rd_i[hit_way_i], l1d_pkg::addr_word(req_r.addr));
        end
    end

    mem_req_stable: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o)
    );

endmodule

`default_nettype wire

// ==== hw/l1d_pkg.sv ====
`default_nettype none

package l1d_pkg;

    // Cache geometry
    localparam int unsigned ADDR_W  = 32;
    localparam int unsigned WORD_W  = 32;
    localparam int unsigned BLOCK_W = 128;
    localparam int unsigned WAYS    = 4;
    localparam int unsigned SETS    = 16;

    localparam int unsigned WAY_W   = $clog2(WAYS);
    localparam int unsigned SET_W   = $clog2(SETS);
    localparam int unsigned OFF_W   = $clog2(BLOCK_W / 8);
    localparam int unsigned TAG_W   = ADDR_W - SET_W - OFF_W;

    // Word position inside a block
    localparam int unsigned WORDS   = BLOCK_W / WORD_W;
    localparam int unsigned WIDX_W  = $clog2(WORDS);
    localparam int unsigned BOFF_W  = $clog2(WORD_W / 8);

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [BLOCK_W-1:0] block_t;
    typedef logic [WAY_W-1:0]   way_idx_t;
    typedef logic [SET_W-1:0]   set_idx_t;
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [WIDX_W-1:0]  word_idx_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } tag_entry_t;

    typedef struct packed {
        logic  write;
        addr_t addr;
        word_t data;
    } cache_req_t;

    // Block transfer to or from main memory, addr is block aligned
    typedef struct packed {
        logic   write;
        addr_t  addr;
        block_t data;
    } mem_req_t;

    function automatic tag_t addr_tag(addr_t addr);
        return addr[ADDR_W-1 -: TAG_W];
    endfunction

    function automatic set_idx_t addr_set(addr_t addr);
        return addr[OFF_W +: SET_W];
    endfunction

    function automatic word_idx_t addr_word(addr_t addr);
        return addr[BOFF_W +: WIDX_W];
    endfunction

    function automatic addr_t block_addr(tag_t tag, set_idx_t set);
        return {tag, set, {OFF_W{1'b0}}};
    endfunction

endpackage

`default_nettype wire

// ==== hw/l1d_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module l1d_top (
    input  logic                 clk_i,
    input  logic                 rstn_i,

    input  l1d_pkg::cache_req_t  req_i,
    input  logic                 req_valid_i,
    output logic                 req_ready_o,

    output l1d_pkg::word_t       rsp_data_o,
    output logic                 rsp_valid_o,
    input  logic                 rsp_ready_i,

    output l1d_pkg::mem_req_t    mem_req_o,
    output logic                 mem_req_valid_o,
    input  logic                 mem_req_ready_i,

    input  l1d_pkg::block_t      mem_rsp_data_i,
    input  logic                 mem_rsp_valid_i,
    output logic                 mem_rsp_ready_o
);

    l1d_pkg::tag_entry_t [l1d_pkg::WAYS-1:0] tag_rd;
    l1d_pkg::block_t [l1d_pkg::WAYS-1:0]     blk_rd;

    logic                hit;
    logic                evict;
    l1d_pkg::way_idx_t   hit_way;
    l1d_pkg::way_idx_t   victim_way;
    l1d_pkg::tag_t       cmp_tag;

    l1d_pkg::set_idx_t   rd_set;
    l1d_pkg::set_idx_t   wr_set;
    l1d_pkg::way_idx_t   wr_way;
    logic                tag_wr_en;
    logic                blk_wr_en;
    l1d_pkg::tag_entry_t tag_wr;
    l1d_pkg::block_t     blk_wr;

    l1d_fsm u_fsm (
        .clk_i,
        .rstn_i,
        .req_i,
        .req_valid_i,
        .req_ready_o,
        .rsp_data_o,
        .rsp_valid_o,
        .rsp_ready_i,
        .mem_req_o,
        .mem_req_valid_o,
        .mem_req_ready_i,
        .mem_rsp_data_i,
        .mem_rsp_valid_i,
        .mem_rsp_ready_o,
        .tag_rd_i     (tag_rd),
        .blk_rd_i     (blk_rd),
        .hit_i        (hit),
        .hit_way_i    (hit_way),
        .victim_way_i (victim_way),
        .evict_o      (evict),
        .cmp_tag_o    (cmp_tag),
        .arr_rd_set_o (rd_set),
        .tag_wr_en_o  (tag_wr_en),
        .blk_wr_en_o  (blk_wr_en),
        .arr_wr_set_o (wr_set),
        .arr_wr_way_o (wr_way),
        .tag_wr_o     (tag_wr),
        .blk_wr_o     (blk_wr)
    );

    way_select u_select (
        .clk_i,
        .rstn_i,
        .entries_i    (tag_rd),
        .tag_i        (cmp_tag),
        .evict_i      (evict),
        .hit_o        (hit),
        .hit_way_o    (hit_way),
        .victim_way_o (victim_way)
    );

    way_array #(
        .entry_t (l1d_pkg::tag_entry_t)
    ) u_tags (
        .clk_i,
        .rstn_i,
        .rd_set_i     (rd_set),
        .rd_entries_o (tag_rd),
        .wr_en_i      (tag_wr_en),
        .wr_set_i     (wr_set),
        .wr_way_i     (wr_way),
        .wr_entry_i   (tag_wr)
    );

    way_array #(
        .entry_t (l1d_pkg::block_t)
    ) u_blocks (
        .clk_i,
        .rstn_i,
        .rd_set_i     (rd_set),
        .rd_entries_o (blk_rd),
        .wr_en_i      (blk_wr_en),
        .wr_set_i     (wr_set),
        .wr_way_i     (wr_way),
        .wr_entry_i   (blk_wr)
    );

endmodule

`default_nettype wire

// ==== hw/way_array.sv ====
`timescale 1ns/100ps
`default_nettype none

module way_array #(
    parameter type entry_t = logic
) (
    input  logic                              clk_i,
    input  logic                              rstn_i,

    input  l1d_pkg::set_idx_t                 rd_set_i,
    output entry_t [l1d_pkg::WAYS-1:0]        rd_entries_o,

    input  logic                              wr_en_i,
    input  l1d_pkg::set_idx_t                 wr_set_i,
    input  l1d_pkg::way_idx_t                 wr_way_i,
    input  entry_t                            wr_entry_i
);

    entry_t [l1d_pkg::WAYS-1:0] mem_r [l1d_pkg::SETS];

    // Registered read, a write in the same cycle is seen on the next read
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int s = 0; s < l1d_pkg::SETS; s++) begin
                mem_r[s] <= '0;
            end
            rd_entries_o <= '0;
        end else begin
            if (wr_en_i) begin
                mem_r[wr_set_i][wr_way_i] <= wr_entry_i;
            end
            rd_entries_o <= mem_r[rd_set_i];
        end
    end

    wr_target_known: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        wr_en_i |-> !$isunknown({wr_set_i, wr_way_i}) && (int'(wr_way_i) < l1d_pkg::WAYS)
    );

endmodule

`default_nettype wire

// ==== hw/way_select.sv ====
`timescale 1ns/100ps
`default_nettype none

module way_select (
    input  logic                                      clk_i,
    input  logic                                      rstn_i,

    input  l1d_pkg::tag_entry_t [l1d_pkg::WAYS-1:0]   entries_i,
    input  l1d_pkg::tag_t                             tag_i,
    input  logic                                      evict_i,

    output logic                                      hit_o,
    output l1d_pkg::way_idx_t                         hit_way_o,
    output l1d_pkg::way_idx_t                         victim_way_o
);

    logic [l1d_pkg::WAYS-1:0] match;
    logic                     has_free;
    l1d_pkg::way_idx_t        free_way;
    l1d_pkg::way_idx_t        rr_r;

    always_comb begin
        for (int w = 0; w < l1d_pkg::WAYS; w++) begin
            match[w] = entries_i[w].valid && (entries_i[w].tag == tag_i);
        end
    end

    // Walk downwards so the lowest matching or invalid way wins
    always_comb begin
        hit_way_o = '0;
        free_way  = '0;
        has_free  = 1'b0;
        for (int w = l1d_pkg::WAYS - 1; w >= 0; w--) begin
            if (match[w]) begin
                hit_way_o = l1d_pkg::way_idx_t'(w);
            end
            if (!entries_i[w].valid) begin
                free_way = l1d_pkg::way_idx_t'(w);
                has_free = 1'b1;
            end
        end
    end

    assign hit_o        = |match;
    assign victim_way_o = has_free ? free_way : rr_r;

    // Round-robin eviction counter
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            rr_r <= '0;
        end else if (evict_i) begin
            if (rr_r == l1d_pkg::way_idx_t'(l1d_pkg::WAYS - 1)) begin
                rr_r <= '0;
            end else begin
                rr_r <= rr_r + 1'b1;
            end
        end
    end

    // A set never holds the same tag twice
    single_match: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        $onehot0(match)
    );

endmodule

`default_nettype wire

// ==== l1d_cache.f ====
hw/l1d_pkg.sv
hw/way_array.sv
hw/way_select.sv
hw/l1d_fsm.sv
hw/l1d_top.sv
bench/mem_model.sv
bench/l1d_tb.sv
